/* Bender.yml */
package:
  name: cache

sources:
  - source/cache_pkg.sv
  - source/cache_ctrl.sv
  - source/cache_tag_array.sv
  - source/cache_data_array.sv
  - source/cache_top.sv
  - target: test
    files:
      - verif/tb_mem_model.sv
      - verif/tb_cache.sv

/* cache.f */
source/cache_pkg.sv
source/cache_ctrl.sv
source/cache_tag_array.sv
source/cache_data_array.sv
source/cache_top.sv
verif/tb_mem_model.sv
verif/tb_cache.sv

/* source/cache_ctrl.sv */
/* Blocking cache controller. Latches one request, walks the
   tag check, eviction and refill states, and builds all port messages */
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl (
  input  wire                              clk,
  input  wire                              reset,
  input  wire                              cachereq_val,
  output logic                             cachereq_rdy,
  input  wire cache_pkg::cache_req_t       cachereq_msg,
  output logic                             cacheresp_val,
  input  wire                              cacheresp_rdy,
  output cache_pkg::cache_resp_t           cacheresp_msg,
  output logic                             memreq_val,
  input  wire                              memreq_rdy,
  output cache_pkg::mem_req_t              memreq_msg,
  input  wire                              memresp_val,
  output logic                             memresp_rdy,
  input  wire cache_pkg::mem_resp_t        memresp_msg,
  output logic [cache_pkg::addr_w-1:0]     req_addr,
  input  wire cache_pkg::tag_status_t      status,
  output cache_pkg::tag_update_t           tag_upd,
  output cache_pkg::data_cmd_t             data_cmd,
  input  wire [cache_pkg::data_w-1:0]      rd_word,
  input  wire [cache_pkg::line_w-1:0]      rd_line
);

  cache_pkg::ctrl_state_e       state_q;
  cache_pkg::ctrl_state_e       state_d;
  cache_pkg::cache_req_t        req_q;
  logic                         hit_q;
  logic [cache_pkg::data_w-1:0] resp_data_q;
  logic [cache_pkg::addr_w-1:0] evict_addr_q;
  logic [cache_pkg::line_w-1:0] evict_line_q;
  logic [cache_pkg::line_w-1:0] refill_line_q;
  logic                         init_way;

  // Init reuses a present line, else takes the victim
  assign init_way = status.hit ? status.hit_way : status.victim_way;

  // ----------------------------------------
  // State register and transitions
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= cache_pkg::idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      cache_pkg::idle: if (cachereq_val) state_d = cache_pkg::tag_check;
      cache_pkg::tag_check: begin
        if (req_q.msg_type == cache_pkg::msg_init)
          state_d = cache_pkg::init_access;
        else if (status.hit && req_q.msg_type == cache_pkg::msg_write)
          state_d = cache_pkg::write_access;
        else if (status.hit)
          state_d = cache_pkg::read_access;
        else if (status.victim_valid && status.victim_dirty)
          state_d = cache_pkg::evict_prepare;
        else
          state_d = cache_pkg::refill_request;
      end
      cache_pkg::init_access,
      cache_pkg::read_access,
      cache_pkg::write_access:   state_d = cache_pkg::wait_resp;
      cache_pkg::evict_prepare:  state_d = cache_pkg::evict_request;
      cache_pkg::evict_request:  if (memreq_rdy) state_d = cache_pkg::evict_wait;
      cache_pkg::evict_wait:     if (memresp_val) state_d = cache_pkg::refill_request;
      cache_pkg::refill_request: if (memreq_rdy) state_d = cache_pkg::refill_wait;
      cache_pkg::refill_wait:    if (memresp_val) state_d = cache_pkg::refill_update;
      cache_pkg::refill_update: begin
        // Finish as a hit on the freshly installed line
        if (req_q.msg_type == cache_pkg::msg_write)
          state_d = cache_pkg::write_access;
        else
          state_d = cache_pkg::read_access;
      end
      cache_pkg::wait_resp:      if (cacheresp_rdy) state_d = cache_pkg::idle;
      default:                   state_d = cache_pkg::idle;
    endcase
  end

  // ----------------------------------------
  // Request latch and datapath registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      req_q <= '0;
    end else if (state_q == cache_pkg::idle && cachereq_val) begin
      req_q <= cachereq_msg;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == cache_pkg::tag_check) begin
      hit_q       <= status.hit;   // Miss path keeps this at 0
      resp_data_q <= '0;
    end
    if (state_q == cache_pkg::read_access) begin
      resp_data_q <= rd_word;
    end
    if (state_q == cache_pkg::evict_prepare) begin
      evict_addr_q <= {status.victim_tag, {cache_pkg::offset_w{1'b0}}};
      evict_line_q <= rd_line;
    end
    if (state_q == cache_pkg::refill_wait && memresp_val) begin
      refill_line_q <= memresp_msg.data;
    end
  end

  // ----------------------------------------
  // Handshakes and messages
  // ----------------------------------------
  assign req_addr      = req_q.addr;
  assign cachereq_rdy  = (state_q == cache_pkg::idle);
  assign cacheresp_val = (state_q == cache_pkg::wait_resp);
  assign memreq_val    = (state_q == cache_pkg::evict_request) ||
                         (state_q == cache_pkg::refill_request);
  assign memresp_rdy   = (state_q == cache_pkg::evict_wait) ||
                         (state_q == cache_pkg::refill_wait);

  always_comb begin
    cacheresp_msg.msg_type = req_q.msg_type;   // Echoed from the request
    cacheresp_msg.opaque   = req_q.opaque;
    cacheresp_msg.hit      = {1'b0, hit_q};
    cacheresp_msg.data     = resp_data_q;
  end

  always_comb begin
    memreq_msg.opaque = req_q.opaque;
    if (state_q == cache_pkg::evict_request) begin
      memreq_msg.msg_type = cache_pkg::msg_write;
      memreq_msg.addr     = evict_addr_q;
      memreq_msg.data     = evict_line_q;
    end else begin
      memreq_msg.msg_type = cache_pkg::msg_read;
      memreq_msg.addr     = {req_q.addr[cache_pkg::addr_w-1:cache_pkg::offset_w],
                             {cache_pkg::offset_w{1'b0}}};
      memreq_msg.data     = '0;
    end
  end

  // Array commands stay quiet outside the access states
  always_comb begin
    tag_upd           = '0;
    data_cmd          = '0;
    data_cmd.word_sel = req_q.addr[cache_pkg::offset_w-1 -: cache_pkg::word_sel_w];
    data_cmd.word     = req_q.data;
    data_cmd.line     = refill_line_q;
    case (state_q)
      cache_pkg::init_access: begin
        tag_upd.install     = !status.hit;
        tag_upd.touch       = 1'b1;
        tag_upd.way         = init_way;
        data_cmd.way        = init_way;
        data_cmd.write_word = 1'b1;
      end
      cache_pkg::read_access: begin
        tag_upd.touch = 1'b1;
        tag_upd.way   = status.hit_way;
        data_cmd.way  = status.hit_way;
      end
      cache_pkg::write_access: begin
        tag_upd.touch       = 1'b1;
        tag_upd.set_dirty   = 1'b1;
        tag_upd.way         = status.hit_way;
        data_cmd.way        = status.hit_way;
        data_cmd.write_word = 1'b1;
      end
      cache_pkg::evict_prepare: data_cmd.way = status.victim_way;
      cache_pkg::refill_update: begin
        tag_upd.install     = 1'b1;   // Installed clean
        tag_upd.way         = status.victim_way;
        data_cmd.way        = status.victim_way;
        data_cmd.write_line = 1'b1;
      end
      default: ;
    endcase
  end

  a_resp_hold : assert property (
    @(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=> cacheresp_val && $stable(cacheresp_msg)
  );

endmodule

`default_nettype wire

/* source/cache_data_array.sv */
/* Line storage for both ways. Whole-line refill writes, single word
   writes, and combinational word and line reads of the selected way */
`timescale 1ns/100ps
`default_nettype none

module cache_data_array #(
  parameter int num_sets = 8
) (
  input  wire                              clk,
  input  wire cache_pkg::data_cmd_t        data_cmd,
  input  wire [cache_pkg::addr_w-1:0]      req_addr,
  output logic [cache_pkg::data_w-1:0]     rd_word,
  output logic [cache_pkg::line_w-1:0]     rd_line
);

  localparam int idx_w = $clog2(num_sets);

  logic [cache_pkg::line_w-1:0] line_q [2][num_sets];
  logic [idx_w-1:0]             idx;
  logic [cache_pkg::line_w-1:0] cur_line;

  assign idx      = req_addr[cache_pkg::offset_w +: idx_w];
  assign cur_line = line_q[data_cmd.way][idx];

  // ----------------------------------------
  // Writes
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (data_cmd.write_line) begin
      line_q[data_cmd.way][idx] <= data_cmd.line;
    end else if (data_cmd.write_word) begin
      // Insert one word and keep the rest of the line
      line_q[data_cmd.way][idx][data_cmd.word_sel*cache_pkg::data_w +: cache_pkg::data_w]
        <= data_cmd.word;
    end
  end

  // ----------------------------------------
  // Reads
  // ----------------------------------------
  assign rd_line = cur_line;   // Victim line for write-back
  assign rd_word = cur_line[data_cmd.word_sel*cache_pkg::data_w +: cache_pkg::data_w];

  // Refill and store are separate controller states
  a_one_write : assert property (
    @(posedge clk) !(data_cmd.write_word && data_cmd.write_line)
  );

endmodule

`default_nettype wire

/* source/cache_pkg.sv */
/* Geometry, message formats and controller states shared by the
   two-way blocking data cache and its testbench */
`default_nettype none

package cache_pkg;

  // ----------------------------------------
  // Geometry
  // ----------------------------------------
  localparam int addr_w     = 32;
  localparam int data_w     = 32;
  localparam int line_w     = 128;
  localparam int opaque_w   = 8;
  localparam int offset_w   = 4;                  // Byte offset within a line
  localparam int word_sel_w = 2;
  localparam int tag_w      = addr_w - offset_w;  // Whole address above the offset

  typedef enum logic [2:0] {
    msg_read  = 3'd0,
    msg_write = 3'd1,
    msg_init  = 3'd2
  } msg_type_e;

  typedef enum logic [3:0] {
    idle,
    tag_check,
    init_access,
    read_access,
    write_access,
    evict_prepare,
    evict_request,
    evict_wait,
    refill_request,
    refill_wait,
    refill_update,
    wait_resp
  } ctrl_state_e;

  // ----------------------------------------
  // Port messages
  // ----------------------------------------
  typedef struct packed {
    msg_type_e             msg_type;
    logic [opaque_w-1:0]   opaque;
    logic [addr_w-1:0]     addr;
    logic [data_w-1:0]     data;
  } cache_req_t;

  typedef struct packed {
    msg_type_e             msg_type;
    logic [opaque_w-1:0]   opaque;
    logic [1:0]            hit;     // Low bit only
    logic [data_w-1:0]     data;
  } cache_resp_t;

  typedef struct packed {
    msg_type_e             msg_type;
    logic [opaque_w-1:0]   opaque;
    logic [addr_w-1:0]     addr;
    logic [line_w-1:0]     data;
  } mem_req_t;

  typedef struct packed {
    msg_type_e             msg_type;
    logic [opaque_w-1:0]   opaque;
    logic [line_w-1:0]     data;
  } mem_resp_t;

  // Internal commands between controller and arrays
  typedef struct packed {
    logic                  hit;
    logic                  hit_way;
    logic                  victim_way;
    logic                  victim_valid;
    logic                  victim_dirty;
    logic [tag_w-1:0]      victim_tag;
  } tag_status_t;

  typedef struct packed {
    logic                  install;
    logic                  touch;
    logic                  set_dirty;
    logic                  way;
  } tag_update_t;

  typedef struct packed {
    logic                  way;
    logic [word_sel_w-1:0] word_sel;
    logic                  write_word;
    logic                  write_line;
    logic [data_w-1:0]     word;
    logic [line_w-1:0]     line;
  } data_cmd_t;

endpackage

`default_nettype wire

/* source/cache_tag_array.sv */
/* Tag, valid, dirty and LRU state for both ways of every set.
   Decodes hit and victim for the latched address each cycle */
`timescale 1ns/100ps
`default_nettype none

module cache_tag_array #(
  parameter int num_sets = 8
) (
  input  wire                              clk,
  input  wire                              reset,
  input  wire [cache_pkg::addr_w-1:0]      req_addr,
  input  wire cache_pkg::tag_update_t      tag_upd,
  output cache_pkg::tag_status_t           status
);

  localparam int idx_w = $clog2(num_sets);

  logic [idx_w-1:0]             idx;
  logic [cache_pkg::tag_w-1:0]  addr_tag;
  logic [cache_pkg::tag_w-1:0]  tag_q [2][num_sets];
  logic [1:0]                   valid_q [num_sets];   // One bit per way
  logic [1:0]                   dirty_q [num_sets];
  logic [num_sets-1:0]          lru_q;                // Names the next victim
  logic [1:0]                   match;
  logic                         victim;

  assign idx      = req_addr[cache_pkg::offset_w +: idx_w];
  assign addr_tag = req_addr[cache_pkg::addr_w-1:cache_pkg::offset_w];

  // ----------------------------------------
  // Hit and victim decode
  // ----------------------------------------
  assign match[0] = valid_q[idx][0] && (tag_q[0][idx] == addr_tag);
  assign match[1] = valid_q[idx][1] && (tag_q[1][idx] == addr_tag);
  assign victim   = lru_q[idx];

  always_comb begin
    status.hit          = |match;
    status.hit_way      = match[1];
    status.victim_way   = victim;
    status.victim_valid = valid_q[idx][victim];
    status.victim_dirty = dirty_q[idx][victim];
    status.victim_tag   = tag_q[victim][idx];   // Write-back address source
  end

  // ----------------------------------------
  // Updates
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (tag_upd.install) begin
      tag_q[tag_upd.way][idx] <= addr_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < num_sets; s++) begin
        valid_q[s] <= 2'b00;
        dirty_q[s] <= 2'b00;
      end
      lru_q <= '0;
    end else begin
      if (tag_upd.install) begin
        valid_q[idx][tag_upd.way] <= 1'b1;
        dirty_q[idx][tag_upd.way] <= tag_upd.set_dirty;   // Clean unless told
      end else if (tag_upd.set_dirty) begin
        dirty_q[idx][tag_upd.way] <= 1'b1;
      end
      // Point away from the way just used
      if (tag_upd.touch) begin
        lru_q[idx] <= ~tag_upd.way;
      end
    end
  end

  // Controller must never install a duplicate tag in a set
  a_single_hit : assert property (
    @(posedge clk) disable iff (reset) !(match[0] && match[1])
  );

endmodule

`default_nettype wire

/* source/cache_top.sv */
/* Top of the 256-byte two-way data cache. Joins the controller to the
   tag and data arrays and exposes the cache and memory handshake ports */
`timescale 1ns/100ps
`default_nettype none

module cache_top #(
  parameter int num_sets = 8
) (
  input  wire                              clk,
  input  wire                              reset,

  // Cache side
  input  wire                              cachereq_val,
  output logic                             cachereq_rdy,
  input  wire cache_pkg::cache_req_t       cachereq_msg,
  output logic                             cacheresp_val,
  input  wire                              cacheresp_rdy,
  output cache_pkg::cache_resp_t           cacheresp_msg,

  // Memory side
  output logic                             memreq_val,
  input  wire                              memreq_rdy,
  output cache_pkg::mem_req_t              memreq_msg,
  input  wire                              memresp_val,
  output logic                             memresp_rdy,
  input  wire cache_pkg::mem_resp_t        memresp_msg
);

  logic [cache_pkg::addr_w-1:0] req_addr;
  cache_pkg::tag_status_t       status;
  cache_pkg::tag_update_t       tag_upd;
  cache_pkg::data_cmd_t         data_cmd;
  logic [cache_pkg::data_w-1:0] rd_word;
  logic [cache_pkg::line_w-1:0] rd_line;

  cache_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cachereq_msg  (cachereq_msg),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .cacheresp_msg (cacheresp_msg),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memreq_msg    (memreq_msg),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .memresp_msg   (memresp_msg),
    .req_addr      (req_addr),
    .status        (status),
    .tag_upd       (tag_upd),
    .data_cmd      (data_cmd),
    .rd_word       (rd_word),
    .rd_line       (rd_line)
  );

  cache_tag_array #(.num_sets(num_sets)) u_tag_array (
    .clk      (clk),
    .reset    (reset),
    .req_addr (req_addr),
    .tag_upd  (tag_upd),
    .status   (status)
  );

  // Line storage for both ways
  cache_data_array #(.num_sets(num_sets)) u_data_array (
    .clk      (clk),
    .data_cmd (data_cmd),
    .req_addr (req_addr),
    .rd_word  (rd_word),
    .rd_line  (rd_line)
  );

endmodule

`default_nettype wire

/* verif/tb_cache.sv */
/* Directed testbench for the two-way data cache. Each test task drives
   requests and checks responses and memory traffic against a tag model */
`timescale 1ns/100ps
`default_nettype none

module tb_cache;

  localparam int num_sets   = 8;
  localparam int idx_w      = $clog2(num_sets);
  localparam int clk_period = 100;
  localparam int num_tests  = 6;

  logic                   clk;
  logic                   reset;
  logic                   cachereq_val;
  logic                   cachereq_rdy;
  cache_pkg::cache_req_t  cachereq_msg;
  logic                   cacheresp_val;
  logic                   cacheresp_rdy;
  cache_pkg::cache_resp_t cacheresp_msg;
  logic                   memreq_val;
  logic                   memreq_rdy;
  cache_pkg::mem_req_t    memreq_msg;
  logic                   memresp_val;
  logic                   memresp_rdy;
  cache_pkg::mem_resp_t   memresp_msg;
  int                     errors;
  int                     checks;
  logic                   mem_pending;   // A memory request awaits its response

  // ----------------------------------------
  // Reference model state
  // ----------------------------------------
  logic [cache_pkg::tag_w-1:0]  ref_tag [2][num_sets];
  logic                         ref_valid [2][num_sets];
  logic                         ref_dirty [2][num_sets];
  logic                         ref_lru [num_sets];
  logic [cache_pkg::data_w-1:0] golden [logic [cache_pkg::addr_w-1:0]];   // Latest written words
  cache_pkg::mem_req_t          mem_log [$];

  cache_top #(.num_sets(num_sets)) DUT (
    .clk (clk), .reset (reset),
    .cachereq_val (cachereq_val), .cachereq_rdy (cachereq_rdy), .cachereq_msg (cachereq_msg),
    .cacheresp_val (cacheresp_val), .cacheresp_rdy (cacheresp_rdy),
    .cacheresp_msg (cacheresp_msg),
    .memreq_val (memreq_val), .memreq_rdy (memreq_rdy), .memreq_msg (memreq_msg),
    .memresp_val (memresp_val), .memresp_rdy (memresp_rdy), .memresp_msg (memresp_msg)
  );

  tb_mem_model u_mem (
    .clk (clk),
    .memreq_val (memreq_val), .memreq_rdy (memreq_rdy), .memreq_msg (memreq_msg),
    .memresp_val (memresp_val), .memresp_rdy (memresp_rdy), .memresp_msg (memresp_msg)
  );

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk) begin
    if (memreq_val && memreq_rdy) mem_log.push_back(memreq_msg);   // Every memory transfer
  end

  // Same background contents as the memory model
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h5ac3_9e17;
  endfunction

  function automatic logic [31:0] arch_word(input logic [31:0] addr);
    logic [31:0] wa;
    wa = {addr[31:2], 2'b00};
    if (golden.exists(wa)) return golden[wa];
    return fill_word(wa);
  endfunction

  function automatic logic [127:0] arch_line(input logic [31:0] line_addr);
    logic [127:0] line;
    for (int w = 0; w < 4; w++) begin
      line[w*32 +: 32] = arch_word(line_addr + 4 * w);
    end
    return line;
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_resp(input string name, input cache_pkg::cache_resp_t exp,
                            input cache_pkg::cache_resp_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_mem_req(input string name, input cache_pkg::mem_req_t exp,
                               input cache_pkg::mem_req_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_int(input string name, input integer exp, input integer act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Mismatch %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  // memresp_rdy is high exactly while a memory request is outstanding
  always @(posedge clk) begin
    if (reset) begin
      mem_pending = 1'b0;
    end else begin
      check_int("memory handshake memresp_rdy", mem_pending, memresp_rdy);
      if (memreq_val && memreq_rdy) mem_pending = 1'b1;
      if (memresp_val && memresp_rdy) mem_pending = 1'b0;
    end
  end

  // Steps the tag model and builds the expected response and write-back
  task automatic predict(input cache_pkg::msg_type_e typ, input logic [7:0] opq,
                         input logic [31:0] addr, input logic [31:0] data,
                         output cache_pkg::cache_resp_t exp_resp, output logic hit,
                         output logic wb, output cache_pkg::mem_req_t wb_req);
    logic [idx_w-1:0]            idx;
    logic [cache_pkg::tag_w-1:0] tag;
    logic                        way;
    idx = addr[cache_pkg::offset_w +: idx_w];
    tag = addr[cache_pkg::addr_w-1:cache_pkg::offset_w];
    hit = 1'b0;
    way = ref_lru[idx];
    for (int w = 0; w < 2; w++) begin
      if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    wb     = !hit && typ != cache_pkg::msg_init && ref_valid[way][idx] && ref_dirty[way][idx];
    wb_req = '0;
    if (wb) begin
      wb_req.msg_type = cache_pkg::msg_write;
      wb_req.opaque   = opq;
      wb_req.addr     = {ref_tag[way][idx], {cache_pkg::offset_w{1'b0}}};
      wb_req.data     = arch_line(wb_req.addr);
    end
    if (!hit) begin
      ref_tag[way][idx]   = tag;
      ref_valid[way][idx] = 1'b1;
      ref_dirty[way][idx] = 1'b0;
    end
    if (typ == cache_pkg::msg_write) ref_dirty[way][idx] = 1'b1;
    ref_lru[idx]      = ~way;
    exp_resp.msg_type = typ;
    exp_resp.opaque   = opq;
    exp_resp.hit      = {1'b0, hit};
    exp_resp.data     = (typ == cache_pkg::msg_read) ? arch_word(addr) : '0;
    if (typ != cache_pkg::msg_read) golden[{addr[31:2], 2'b00}] = data;
  endtask

  // Starts and ends 10 ns after a rising edge
  task automatic issue(input cache_pkg::cache_req_t req, output cache_pkg::cache_resp_t resp,
                       output int lat);
    cachereq_msg = req;
    cachereq_val = 1'b1;
    do @(posedge clk); while (!cachereq_rdy);
    #10 cachereq_val = 1'b0;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!(cacheresp_val && cacheresp_rdy));
    resp = cacheresp_msg;
    #10;
  endtask

  task automatic run_req(input string name, input cache_pkg::msg_type_e typ,
                         input logic [7:0] opq, input logic [31:0] addr, input logic [31:0] data);
    cache_pkg::cache_req_t  req;
    cache_pkg::cache_resp_t exp_resp;
    cache_pkg::cache_resp_t resp;
    cache_pkg::mem_req_t    wb_req;
    cache_pkg::mem_req_t    rd_req;
    logic                   hit;
    logic                   wb;
    int                     lat;
    int                     first;
    req.msg_type = typ;
    req.opaque   = opq;
    req.addr     = addr;
    req.data     = data;
    first        = mem_log.size();
    predict(typ, opq, addr, data, exp_resp, hit, wb, wb_req);
    issue(req, resp, lat);
    check_resp(name, exp_resp, resp);
    if (hit || typ == cache_pkg::msg_init) begin
      check_int({name, " latency"}, 3, lat);
      check_int({name, " memory requests"}, 0, mem_log.size() - first);
    end else begin
      rd_req.msg_type = cache_pkg::msg_read;
      rd_req.opaque   = opq;
      rd_req.addr     = {addr[31:4], 4'h0};
      rd_req.data     = '0;
      check_int({name, " memory requests"}, wb ? 2 : 1, mem_log.size() - first);
      if (mem_log.size() - first == (wb ? 2 : 1)) begin
        if (wb) check_mem_req({name, " write-back"}, wb_req, mem_log[first]);
        check_mem_req({name, " refill"}, rd_req, mem_log[mem_log.size() - 1]);
      end
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_reset();
    @(posedge clk);
    check_int("reset cachereq_rdy", 1, cachereq_rdy);
    check_int("reset cacheresp_val", 0, cacheresp_val);
    check_int("reset memreq_val", 0, memreq_val);
    #10;
  endtask

  task automatic test_init_read();
    run_req("init", cache_pkg::msg_init, 8'h21, 32'h0000_0100, 32'h1234_5678);
    run_req("init read", cache_pkg::msg_read, 8'h22, 32'h0000_0100, '0);
  endtask

  task automatic test_read_miss();
    run_req("read miss", cache_pkg::msg_read, 8'h31, 32'h0000_0224, '0);
    run_req("read again", cache_pkg::msg_read, 8'h32, 32'h0000_0224, '0);
  endtask

  task automatic test_write_back();
    run_req("wb fill", cache_pkg::msg_read, 8'h41, 32'h0000_4030, '0);
    run_req("wb write hit", cache_pkg::msg_write, 8'h42, 32'h0000_4034, 32'hdead_beef);
    run_req("wb other way", cache_pkg::msg_read, 8'h43, 32'h0000_5030, '0);
    run_req("wb evict", cache_pkg::msg_read, 8'h44, 32'h0000_6030, '0);
    run_req("wb reread", cache_pkg::msg_read, 8'h45, 32'h0000_4034, '0);
  endtask

  task automatic test_lru();
    run_req("lru fill a", cache_pkg::msg_read, 8'h51, 32'h0000_1050, '0);
    run_req("lru fill b", cache_pkg::msg_read, 8'h52, 32'h0000_2050, '0);
    run_req("lru touch a", cache_pkg::msg_read, 8'h53, 32'h0000_1050, '0);
    run_req("lru third", cache_pkg::msg_read, 8'h54, 32'h0000_3050, '0);
    run_req("lru a kept", cache_pkg::msg_read, 8'h55, 32'h0000_1050, '0);
    run_req("lru b gone", cache_pkg::msg_read, 8'h56, 32'h0000_2050, '0);
  endtask

  task automatic test_resp_hold();
    cache_pkg::cache_req_t  req;
    cache_pkg::cache_req_t  other;
    cache_pkg::cache_resp_t exp_resp;
    cache_pkg::cache_resp_t held;
    cache_pkg::mem_req_t    wb_req;
    logic                   hit;
    logic                   wb;
    run_req("hold fill", cache_pkg::msg_read, 8'h61, 32'h0000_0370, '0);
    req   = '0;
    other = '0;
    req.msg_type   = cache_pkg::msg_read;
    req.opaque     = 8'h62;
    req.addr       = 32'h0000_0374;
    other.msg_type = cache_pkg::msg_read;
    other.opaque   = 8'hee;
    other.addr     = 32'h0000_0224;
    predict(req.msg_type, req.opaque, req.addr, req.data, exp_resp, hit, wb, wb_req);
    cacheresp_rdy = 1'b0;
    cachereq_msg  = req;
    cachereq_val  = 1'b1;
    do @(posedge clk); while (!cachereq_rdy);
    #10 cachereq_msg = other;   // Offered while the response is held
    do @(posedge clk); while (!cacheresp_val);
    held = cacheresp_msg;
    check_resp("hold response", exp_resp, held);
    repeat (5) begin
      @(posedge clk);
      check_int("hold cacheresp_val", 1, cacheresp_val);
      check_resp("hold stable", held, cacheresp_msg);
      check_int("hold cachereq_rdy", 0, cachereq_rdy);
    end
    #10 cacheresp_rdy = 1'b1;
    @(posedge clk);
    check_int("hold transfer", 1, cacheresp_val);
    #10 cachereq_val = 1'b0;
    @(posedge clk);
    check_int("hold back to idle", 1, cachereq_rdy);
    #10;
  endtask

  // Watchdog
  initial begin
    #(num_tests * 200 * clk_period);
    $display("Error: watchdog timeout, the tests did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin : main
    errors        = 0;
    checks        = 0;
    clk           = 1'b0;
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq_msg  = '0;
    cacheresp_rdy = 1'b1;
    for (int s = 0; s < num_sets; s++) begin
      ref_valid[0][s] = 1'b0;
      ref_valid[1][s] = 1'b0;
      ref_dirty[0][s] = 1'b0;
      ref_dirty[1][s] = 1'b0;
      ref_lru[s]      = 1'b0;
    end
    repeat (3) @(posedge clk);
    #10 reset = 1'b0;
    test_reset();
    test_init_read();
    test_read_miss();
    test_write_back();
    test_lru();
    test_resp_hold();
    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/tb_mem_model.sv */
/* Line-wide memory model for the cache testbench. Answers each memory
   request after 1 to 3 cycles and stalls memreq_rdy at random */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model (
  input  wire                              clk,
  input  wire                              memreq_val,
  output logic                             memreq_rdy,
  input  wire cache_pkg::mem_req_t         memreq_msg,
  output logic                             memresp_val,
  input  wire                              memresp_rdy,
  output cache_pkg::mem_resp_t             memresp_msg
);

  logic [cache_pkg::line_w-1:0] store [logic [cache_pkg::addr_w-1:0]];   // Written lines only
  integer                       seed;

  // Background contents for lines never written
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h5ac3_9e17;
  endfunction

  function automatic logic [127:0] read_line(input logic [31:0] line_addr);
    logic [127:0] line;
    if (store.exists(line_addr)) return store[line_addr];
    for (int w = 0; w < 4; w++) begin
      line[w*32 +: 32] = fill_word(line_addr + 4 * w);
    end
    return line;
  endfunction

  initial begin : serve
    cache_pkg::mem_req_t req;
    int                  delay;
    seed        = 32'hfceb9da2;
    memreq_rdy  = 1'b0;
    memresp_val = 1'b0;
    memresp_msg = '0;
    forever begin
      @(posedge clk);
      if (memreq_val && memreq_rdy) begin
        req   = memreq_msg;
        delay = 1 + $unsigned($random(seed)) % 3;
        #10 memreq_rdy = 1'b0;
        repeat (delay - 1) begin
          @(posedge clk);
          #10;
        end
        if (req.msg_type == cache_pkg::msg_write) begin
          store[req.addr] = req.data;
        end
        memresp_msg.msg_type = req.msg_type;
        memresp_msg.opaque   = req.opaque;
        memresp_msg.data     = (req.msg_type == cache_pkg::msg_write) ? '0 : read_line(req.addr);
        memresp_val          = 1'b1;
        do @(posedge clk); while (!memresp_rdy);
        #10 memresp_val = 1'b0;
      end else begin
        #10;
      end
      memreq_rdy = ($random(seed) & 3) != 0;   // Stall about one cycle in four
    end
  end

endmodule

`default_nettype wire
